/* source/tile_pkg.sv */
// ========================================
// Tile package
// Word widths, TCDM request payload and address field helpers
// ========================================
package tile_pkg;

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned ByteOffset     = $clog2(BeWidth);
  localparam int unsigned MaxOutstanding = 2;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   strb_t;

  // Request payload, 69 bits
  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    strb_t be;
  } tcdm_req_t;

  // Mask of the low bits ones
  function automatic addr_t field_mask(int unsigned bits);
    return (addr_t'(1) << bits) - addr_t'(1);
  endfunction

  // Tile index, sits right above the bank bits
  function automatic addr_t tile_field(addr_t addr, int unsigned bank_bits,
                                       int unsigned tile_bits);
    return (addr >> (ByteOffset + bank_bits)) & field_mask(tile_bits);
  endfunction

  // Word address inside the tile: row then bank, no tile and no byte bits
  function automatic addr_t local_addr(addr_t addr, int unsigned bank_bits,
                                       int unsigned tile_bits);
    addr_t row;
    addr_t bank;
    row  = addr >> (ByteOffset + bank_bits + tile_bits);
    bank = (addr >> ByteOffset) & field_mask(bank_bits);
    return (row << bank_bits) | bank;
  endfunction

  // Tile and bank swapped for routing between tiles
  function automatic addr_t remote_addr(addr_t addr, int unsigned bank_bits,
                                        int unsigned tile_bits);
    addr_t row;
    addr_t bank;
    addr_t tile;
    addr_t offs;
    row  = addr >> (ByteOffset + bank_bits + tile_bits);
    bank = (addr >> ByteOffset) & field_mask(bank_bits);
    tile = tile_field(addr, bank_bits, tile_bits);
    offs = addr & field_mask(ByteOffset);
    return (((((row << bank_bits) | bank) << tile_bits) | tile) << ByteOffset) | offs;
  endfunction

endpackage

/* source/tcdm_if.sv */
// ========================================
// TCDM bus
// req/gnt request channel, vld response without back-pressure
// ========================================
`timescale 1ns/1ps

interface tcdm_if;

  logic                 req;
  logic                 gnt;
  tile_pkg::tcdm_req_t  payload;
  logic                 vld;
  tile_pkg::data_t      rdata;

  modport requester (
    output req,
    output payload,
    input  gnt,
    input  vld,
    input  rdata
  );

  modport responder (
    input  req,
    input  payload,
    output gnt,
    output vld,
    output rdata
  );

  // Passive view for checkers
  modport monitor (
    input req,
    input gnt,
    input payload,
    input vld,
    input rdata
  );

endinterface

/* source/tcdm_router.sv */
// ========================================
// TCDM router
// Splits core requests into local and remote, returns read data
// ========================================
`timescale 1ns/1ps

module tcdm_router #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tile_pkg::data_t   tile_id_i,
  // Core data port
  input  logic              core_req_i,
  input  tile_pkg::addr_t   core_addr_i,
  input  logic              core_wen_i,
  input  tile_pkg::data_t   core_wdata_i,
  input  tile_pkg::strb_t   core_be_i,
  output logic              core_gnt_o,
  output logic              core_vld_o,
  output tile_pkg::data_t   core_rdata_o,
  // Destinations
  tcdm_if.requester         local_bus,
  tcdm_if.requester         remote_bus
);

  localparam int unsigned BankBits = $clog2(NumBanksPerTile);
  localparam int unsigned TileBits = $clog2(NumTiles);
  localparam int unsigned CntWidth = $clog2(tile_pkg::MaxOutstanding + 1);

  logic                is_local;
  logic                dest_gnt;
  logic                read_ok;
  logic                allow;
  logic                rd_issue;
  logic                rd_done;
  logic [CntWidth-1:0] rd_cnt_q;
  // High when the outstanding reads target the local banks
  logic                dest_local_q;

  // Tile field against our own id
  assign is_local = tile_pkg::tile_field(core_addr_i, BankBits, TileBits) ==
                    (tile_id_i & tile_pkg::field_mask(TileBits));

  // Reads only go to one destination at a time, keeps responses in order
  assign read_ok = (rd_cnt_q < CntWidth'(tile_pkg::MaxOutstanding)) &&
                   ((rd_cnt_q == '0) || (dest_local_q == is_local));
  assign allow    = core_wen_i || read_ok;
  assign dest_gnt = is_local ? local_bus.gnt : remote_bus.gnt;

  assign core_gnt_o = dest_gnt && allow;

  // Request forwarding
  assign local_bus.req  = core_req_i && is_local && allow;
  assign remote_bus.req = core_req_i && !is_local && allow;

  assign local_bus.payload.addr  = tile_pkg::local_addr(core_addr_i, BankBits, TileBits);
  assign local_bus.payload.wen   = core_wen_i;
  assign local_bus.payload.wdata = core_wdata_i;
  assign local_bus.payload.be    = core_be_i;

  assign remote_bus.payload.addr  = tile_pkg::remote_addr(core_addr_i, BankBits, TileBits);
  assign remote_bus.payload.wen   = core_wen_i;
  assign remote_bus.payload.wdata = core_wdata_i;
  assign remote_bus.payload.be    = core_be_i;

  // Outstanding read bookkeeping
  assign rd_issue = core_req_i && core_gnt_o && !core_wen_i;
  assign rd_done  = core_vld_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_cnt_q     <= '0;
      dest_local_q <= 1'b0;
    end else begin
      case ({rd_issue, rd_done})
        2'b10:   rd_cnt_q <= rd_cnt_q + CntWidth'(1);
        2'b01:   rd_cnt_q <= rd_cnt_q - CntWidth'(1);
        default: rd_cnt_q <= rd_cnt_q;
      endcase
      if (rd_issue) begin
        dest_local_q <= is_local;
      end
    end
  end

  // Response source follows the destination of the pending reads
  assign core_vld_o   = dest_local_q ? local_bus.vld : remote_bus.vld;
  assign core_rdata_o = dest_local_q ? local_bus.rdata : remote_bus.rdata;

endmodule

/* source/tcdm_spill_reg.sv */
// ========================================
// Remote spill register
// Two entries, cuts the path from remote_gnt_i to the core
// ========================================
`timescale 1ns/1ps

module tcdm_spill_reg (
  input  logic              clk_i,
  input  logic              rst_ni,
  tcdm_if.responder         in_bus,
  // Remote TCDM port
  output logic              remote_req_o,
  output tile_pkg::addr_t   remote_addr_o,
  output logic              remote_wen_o,
  output tile_pkg::data_t   remote_wdata_o,
  output tile_pkg::strb_t   remote_be_o,
  input  logic              remote_gnt_i,
  input  logic              remote_vld_i,
  input  tile_pkg::data_t   remote_rdata_i
);

  // Entry a takes new items, entry b holds the older one on a stall
  logic                a_full_q;
  logic                b_full_q;
  tile_pkg::tcdm_req_t a_data_q;
  tile_pkg::tcdm_req_t b_data_q;
  tile_pkg::tcdm_req_t out_req;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign in_bus.gnt = !a_full_q || !b_full_q;

  assign a_fill  = in_bus.req && in_bus.gnt;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !remote_gnt_i;
  assign b_drain = b_full_q && remote_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_bus.payload;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Oldest entry goes out first
  assign out_req        = b_full_q ? b_data_q : a_data_q;
  assign remote_req_o   = a_full_q || b_full_q;
  assign remote_addr_o  = out_req.addr;
  assign remote_wen_o   = out_req.wen;
  assign remote_wdata_o = out_req.wdata;
  assign remote_be_o    = out_req.be;

  // Responses pass straight back
  assign in_bus.vld   = remote_vld_i;
  assign in_bus.rdata = remote_rdata_i;

endmodule

/* source/tcdm_bank_array.sv */
// ========================================
// Local TCDM banks
// Word-interleaved SRAM, byte-enable writes, one-cycle reads
// ========================================
`timescale 1ns/1ps

module tcdm_bank_array #(
  parameter int unsigned NumBanksPerTile = 4,
  parameter int unsigned BankWords       = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  tcdm_if.responder mem_bus
);

  localparam int unsigned BankBits = $clog2(NumBanksPerTile);
  localparam int unsigned RowBits  = $clog2(BankWords);

  logic [BankBits-1:0] bank_sel;
  logic [BankBits-1:0] bank_sel_q;
  logic [RowBits-1:0]  row;
  logic                rd_req;
  logic                vld_q;
  tile_pkg::data_t     bank_rdata [NumBanksPerTile];

  // Low word bits pick the bank, the bits above pick the row
  assign bank_sel = mem_bus.payload.addr[BankBits-1:0];
  assign row      = mem_bus.payload.addr[BankBits +: RowBits];
  assign rd_req   = mem_bus.req && !mem_bus.payload.wen;

  // Banks never stall
  assign mem_bus.gnt = 1'b1;

  for (genvar b = 0; b < NumBanksPerTile; b++) begin : gen_banks
    tile_pkg::data_t mem_q [BankWords];
    tile_pkg::data_t rdata_q;
    logic            sel;

    assign sel = mem_bus.req && (bank_sel == BankBits'(b));

    always_ff @(posedge clk_i) begin
      if (sel) begin
        if (mem_bus.payload.wen) begin
          for (int i = 0; i < tile_pkg::BeWidth; i++) begin
            if (mem_bus.payload.be[i]) begin
              mem_q[row][8*i +: 8] <= mem_bus.payload.wdata[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem_q[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_req;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign mem_bus.vld   = vld_q;
  assign mem_bus.rdata = bank_rdata[bank_sel_q];

endmodule

/* source/tile_top.sv */
// ========================================
// Compute tile data path
// Core port to local banks or remote TCDM port
// ========================================
`timescale 1ns/1ps

module tile_top #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4,
  parameter int unsigned BankWords       = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tile_pkg::data_t   tile_id_i,
  // Core data port
  input  logic              core_req_i,
  input  tile_pkg::addr_t   core_addr_i,
  input  logic              core_wen_i,
  input  tile_pkg::data_t   core_wdata_i,
  input  tile_pkg::strb_t   core_be_i,
  output logic              core_gnt_o,
  output logic              core_vld_o,
  output tile_pkg::data_t   core_rdata_o,
  // Remote TCDM port
  output logic              remote_req_o,
  output tile_pkg::addr_t   remote_addr_o,
  output logic              remote_wen_o,
  output tile_pkg::data_t   remote_wdata_o,
  output tile_pkg::strb_t   remote_be_o,
  input  logic              remote_gnt_i,
  input  logic              remote_vld_i,
  input  tile_pkg::data_t   remote_rdata_i
);

  tcdm_if local_bus ();
  tcdm_if remote_bus ();

  tcdm_router #(
    .NumTiles        (NumTiles),
    .NumBanksPerTile (NumBanksPerTile)
  ) i_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tile_id_i    (tile_id_i),
    .core_req_i   (core_req_i),
    .core_addr_i  (core_addr_i),
    .core_wen_i   (core_wen_i),
    .core_wdata_i (core_wdata_i),
    .core_be_i    (core_be_i),
    .core_gnt_o   (core_gnt_o),
    .core_vld_o   (core_vld_o),
    .core_rdata_o (core_rdata_o),
    .local_bus    (local_bus.requester),
    .remote_bus   (remote_bus.requester)
  );

  // Registered boundary towards the other tiles
  tcdm_spill_reg i_remote_reg (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_bus         (remote_bus.responder),
    .remote_req_o   (remote_req_o),
    .remote_addr_o  (remote_addr_o),
    .remote_wen_o   (remote_wen_o),
    .remote_wdata_o (remote_wdata_o),
    .remote_be_o    (remote_be_o),
    .remote_gnt_i   (remote_gnt_i),
    .remote_vld_i   (remote_vld_i),
    .remote_rdata_i (remote_rdata_i)
  );

  tcdm_bank_array #(
    .NumBanksPerTile (NumBanksPerTile),
    .BankWords       (BankWords)
  ) i_banks (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .mem_bus (local_bus.responder)
  );

endmodule

/* verif/tb_clk_gen.sv */
// ========================================
// Testbench clock and reset generator
// ========================================
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 4,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #(PeriodNs / 2.0) clk_o = ~clk_o;

endmodule

/* verif/tile_checker.sv */
// ========================================
// Tile port checker
// Local read latency, remote stall and reset rules
// ========================================
`timescale 1ns/1ps

module tile_checker #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4
) (
  input logic            clk_i,
  input logic            rst_ni,
  input tile_pkg::data_t tile_id_i,
  input logic            core_req_i,
  input tile_pkg::addr_t core_addr_i,
  input logic            core_wen_i,
  input logic            core_gnt_i,
  input logic            core_vld_i,
  input logic            remote_req_i,
  input tile_pkg::addr_t remote_addr_i,
  input logic            remote_gnt_i
);

  localparam int unsigned TileLsb  = tile_pkg::ByteOffset + $clog2(NumBanksPerTile);
  localparam int unsigned TileBits = $clog2(NumTiles);

  int unsigned fail_cnt = 0;
  logic        local_rd;

  assign local_rd = core_req_i && core_gnt_i && !core_wen_i &&
                    (core_addr_i[TileLsb +: TileBits] == tile_id_i[TileBits-1:0]);

  a_local_rd_vld : assert property (
    @(posedge clk_i) disable iff (!rst_ni) local_rd |=> core_vld_i
  ) else begin
    fail_cnt++;
    $error("Local read got no response one cycle after its grant");
  end

  // Held request must not change under a stall
  a_remote_stall : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (remote_req_i && !remote_gnt_i) |=> (remote_req_i && $stable(remote_addr_i))
  ) else begin
    fail_cnt++;
    $error("Stalled remote request dropped or changed its address");
  end

  a_reset_quiet : assert property (
    @(posedge clk_i) $rose(rst_ni) |-> (!remote_req_i && !core_vld_i)
  ) else begin
    fail_cnt++;
    $error("Remote request or core response active right after reset");
  end

endmodule

/* verif/tile_tb.sv */
// ========================================
// Tile testbench
// Random core traffic, remote memory responder and scoreboard
// ========================================
`timescale 1ns/1ps

module tile_tb;

  localparam int unsigned NumTiles        = 4;
  localparam int unsigned NumBanksPerTile = 4;
  localparam int unsigned BankWords       = 64;
  localparam int unsigned TileId          = 2;
  localparam int unsigned NumReqs         = 400;
  localparam int unsigned CyclesPerReq    = 12;
  localparam int unsigned GntPercent      = 60;
  localparam int unsigned BankBits        = $clog2(NumBanksPerTile);
  localparam int unsigned TileBits        = $clog2(NumTiles);
  localparam int unsigned BankLsb         = 2;
  localparam int unsigned TileLsb         = BankLsb + BankBits;
  localparam int unsigned RowLsb          = TileLsb + TileBits;
  // Few rows so that addresses come back often
  localparam int unsigned RowsUsedBits    = 3;
  localparam int unsigned ModelBits       = RowLsb + RowsUsedBits;

  logic            clk_i;
  logic            rst_ni;
  tile_pkg::data_t tile_id_i;
  logic            core_req_i;
  tile_pkg::addr_t core_addr_i;
  logic            core_wen_i;
  tile_pkg::data_t core_wdata_i;
  tile_pkg::strb_t core_be_i;
  logic            core_gnt_o;
  logic            core_vld_o;
  tile_pkg::data_t core_rdata_o;
  logic            remote_req_o;
  tile_pkg::addr_t remote_addr_o;
  logic            remote_wen_o;
  tile_pkg::data_t remote_wdata_o;
  tile_pkg::strb_t remote_be_o;
  logic            remote_gnt_i;
  logic            remote_vld_i;
  tile_pkg::data_t remote_rdata_i;

  tile_pkg::tcdm_req_t exp_rem_q [$];
  tile_pkg::data_t     exp_rd_q [$];
  tile_pkg::data_t     resp_data_q [$];
  int unsigned         resp_due_q [$];
  tile_pkg::data_t     remote_mem [tile_pkg::addr_t];
  // Flat byte memory by original address
  logic [7:0]          model_mem [2**ModelBits];
  bit                  written [2**(ModelBits-2)];
  int unsigned         cycle_cnt;

  assign tile_id_i = tile_pkg::data_t'(TileId);

  tb_clk_gen #(.PeriodNs(4), .ResetCycles(3)) i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tile_top #(
    .NumTiles        (NumTiles),
    .NumBanksPerTile (NumBanksPerTile),
    .BankWords       (BankWords)
  ) uut (.*);

  bind tile_top tile_checker #(
    .NumTiles        (NumTiles),
    .NumBanksPerTile (NumBanksPerTile)
  ) i_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tile_id_i     (tile_id_i),
    .core_req_i    (core_req_i),
    .core_addr_i   (core_addr_i),
    .core_wen_i    (core_wen_i),
    .core_gnt_i    (core_gnt_o),
    .core_vld_i    (core_vld_o),
    .remote_req_i  (remote_req_o),
    .remote_addr_i (remote_addr_o),
    .remote_gnt_i  (remote_gnt_i)
  );

  task automatic report_fail(string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, tile_pkg::data_t act, tile_pkg::data_t exp);
    if (act !== exp) begin
      report_fail($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_addr(string name, tile_pkg::addr_t act, tile_pkg::addr_t exp);
    if (act !== exp) begin
      report_fail($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_strb(string name, tile_pkg::strb_t act, tile_pkg::strb_t exp);
    if (act !== exp) begin
      report_fail($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      report_fail($sformatf("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  function automatic bit is_local_addr(tile_pkg::addr_t a);
    return a[TileLsb +: TileBits] == TileBits'(TileId);
  endfunction

  // Remote order is row, bank, tile, byte
  function automatic tile_pkg::addr_t swap_fields(tile_pkg::addr_t a);
    return {a[tile_pkg::AddrWidth-1:RowLsb], a[BankLsb +: BankBits],
            a[TileLsb +: TileBits], a[BankLsb-1:0]};
  endfunction

  function automatic tile_pkg::addr_t make_addr(bit to_local);
    tile_pkg::addr_t a;
    a = '0;
    a[BankLsb +: BankBits]    = BankBits'($urandom);
    a[RowLsb +: RowsUsedBits] = RowsUsedBits'($urandom);
    if (to_local) begin
      a[TileLsb +: TileBits] = TileBits'(TileId);
    end else begin
      a[TileLsb +: TileBits] = TileBits'(TileId + 1 + $urandom_range(NumTiles - 2));
    end
    return a;
  endfunction

  function automatic tile_pkg::data_t model_read(tile_pkg::addr_t a);
    tile_pkg::data_t d;
    for (int i = 0; i < tile_pkg::BeWidth; i++) begin
      d[8*i +: 8] = model_mem[a[ModelBits-1:0] + i];
    end
    return d;
  endfunction

  function automatic void model_write(tile_pkg::addr_t a, tile_pkg::data_t d,
                                      tile_pkg::strb_t be);
    for (int i = 0; i < tile_pkg::BeWidth; i++) begin
      if (be[i]) begin
        model_mem[a[ModelBits-1:0] + i] = d[8*i +: 8];
      end
    end
  endfunction

  // Scoreboard on the core port
  always @(posedge clk_i) begin : core_monitor
    if (uut.i_checker.fail_cnt != 0) begin
      report_fail("An assertion in the tile checker failed");
    end
    if (core_vld_o) begin
      if (exp_rd_q.size() == 0) begin
        report_fail("Read response arrived with no read outstanding");
      end else begin
        check_data("core_rdata_o", core_rdata_o, exp_rd_q.pop_front());
      end
    end
    if (core_req_i && core_gnt_o) begin
      if (core_wen_i) begin
        model_write(core_addr_i, core_wdata_i, core_be_i);
      end else begin
        exp_rd_q.push_back(model_read(core_addr_i));
      end
      if (!is_local_addr(core_addr_i)) begin
        exp_rem_q.push_back('{addr: swap_fields(core_addr_i), wen: core_wen_i,
                              wdata: core_wdata_i, be: core_be_i});
      end
    end
  end

  // Remote tile memory, random grants, in-order delayed read data
  always @(posedge clk_i) begin : remote_responder
    tile_pkg::tcdm_req_t exp;
    tile_pkg::data_t     word;
    int unsigned         due;
    cycle_cnt++;
    if (remote_req_o && remote_gnt_i) begin
      if (exp_rem_q.size() == 0) begin
        report_fail("Remote port carried a request that the core never issued");
      end else begin
        exp = exp_rem_q.pop_front();
        check_addr("remote_addr_o", remote_addr_o, exp.addr);
        check_flag("remote_wen_o", remote_wen_o, exp.wen);
        check_data("remote_wdata_o", remote_wdata_o, exp.wdata);
        check_strb("remote_be_o", remote_be_o, exp.be);
      end
      word = remote_mem.exists(remote_addr_o) ? remote_mem[remote_addr_o] : '0;
      if (remote_wen_o) begin
        for (int i = 0; i < tile_pkg::BeWidth; i++) begin
          if (remote_be_o[i]) begin
            word[8*i +: 8] = remote_wdata_o[8*i +: 8];
          end
        end
        remote_mem[remote_addr_o] = word;
      end else begin
        due = cycle_cnt + $urandom_range(5, 1);
        if (resp_due_q.size() != 0 && due <= resp_due_q[$]) begin
          due = resp_due_q[$] + 1;
        end
        resp_due_q.push_back(due);
        resp_data_q.push_back(word);
      end
    end
    remote_gnt_i <= ($urandom_range(99) < GntPercent);
    if (resp_due_q.size() != 0 && cycle_cnt >= resp_due_q[0]) begin
      void'(resp_due_q.pop_front());
      remote_rdata_i <= resp_data_q.pop_front();
      remote_vld_i   <= 1'b1;
    end else begin
      remote_vld_i <= 1'b0;
    end
  end

  initial begin : watchdog
    repeat (NumReqs * CyclesPerReq) @(posedge clk_i);
    report_fail("Timeout: the test did not finish in time");
  end

  initial begin : stimulus
    tile_pkg::addr_t addr;
    logic            wen;
    tile_pkg::strb_t be;
    int unsigned     drain;
    void'($urandom(32'h4aa5ffc2));
    core_req_i     = 1'b0;
    core_addr_i    = '0;
    core_wen_i     = 1'b0;
    core_wdata_i   = '0;
    core_be_i      = '0;
    remote_gnt_i   = 1'b0;
    remote_vld_i   = 1'b0;
    remote_rdata_i = '0;
    cycle_cnt      = 0;
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    for (int n = 0; n < NumReqs; n++) begin
      addr = make_addr($urandom_range(1) == 1);
      wen  = 1'($urandom_range(1));
      be   = tile_pkg::strb_t'($urandom);
      // First touch of a word writes all of it
      if (!written[addr[ModelBits-1:2]]) begin
        wen = 1'b1;
        be  = '1;
      end
      written[addr[ModelBits-1:2]] = 1'b1;
      if ($urandom_range(3) == 0) begin
        core_req_i <= 1'b0;
        @(posedge clk_i);
      end
      core_req_i   <= 1'b1;
      core_addr_i  <= addr;
      core_wen_i   <= wen;
      core_wdata_i <= tile_pkg::data_t'($urandom);
      core_be_i    <= be;
      @(posedge clk_i);
      while (!core_gnt_o) begin
        @(posedge clk_i);
      end
    end
    core_req_i <= 1'b0;
    drain = 0;
    while ((exp_rd_q.size() != 0 || exp_rem_q.size() != 0) && drain < 100) begin
      @(posedge clk_i);
      drain++;
    end
    repeat (4) @(posedge clk_i);
    if (exp_rd_q.size() != 0 || exp_rem_q.size() != 0) begin
      report_fail("Requests still outstanding at the end of the test");
    end else if (uut.i_checker.fail_cnt != 0) begin
      report_fail("An assertion in the tile checker failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* sources.f */
source/tile_pkg.sv
source/tcdm_if.sv
source/tcdm_router.sv
source/tcdm_spill_reg.sv
source/tcdm_bank_array.sv
source/tile_top.sv
verif/tb_clk_gen.sv
verif/tile_checker.sv
verif/tile_tb.sv

/* Bender.yml */
package:
  name: tile_tcdm

sources:
  - files:
      - source/tile_pkg.sv
      - source/tcdm_if.sv
      - source/tcdm_router.sv
      - source/tcdm_spill_reg.sv
      - source/tcdm_bank_array.sv
      - source/tile_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tile_checker.sv
      - verif/tile_tb.sv
